//--- logic/av_pkg.sv
// audio/video package
// pixel colours for the scaler output, MCLK accumulator constants
// and the I2S frame layout

`default_nettype none

package av_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // video

  typedef logic [23:0] rgb_t;

  // monochrome panel, lit pixels white
  localparam rgb_t RGB_ON  = 24'hFF_FF_FF;
  localparam rgb_t RGB_OFF = 24'h00_00_00;

  ////////////////////////////////////////////////////////////////////////////
  // audio

  // fractional divider, 74.25 MHz down to a ~12.288 MHz mclk
  typedef logic [21:0] accum_t;
  localparam accum_t MCLK_STEP = 22'd245760;
  localparam accum_t MCLK_WRAP = 22'd742500;

  // mclk periods per bit clock period
  localparam int SCLK_DIV = 4;

  // 32 bit slots, 16 live bits then padding
  localparam int SLOT_BITS   = 32;
  localparam int ACTIVE_BITS = 16;

  typedef logic signed [15:0] sample_t;

  // one buzzer at a quarter of full scale
  localparam sample_t TONE_LEVEL = 16'sh2000;

endpackage

`default_nettype wire

//--- logic/core_top.sv
// handheld core top level
// ROM loading and fetch arbitration, scaler video cleanup and I2S audio,
// all on clk_74a. bridge reads come back through a combinational mux

`timescale 1ns/1ps
`default_nettype none

module core_top
  import rom_pkg::*;
  import av_pkg::*;
(
  input  wire                  clk_74a,
  input  wire                  rst_n,
  // bridge bus
  input  wire bus_addr_t       bridge_addr,
  input  wire                  bridge_wr,
  input  wire                  bridge_rd,
  input  wire bus_data_t       bridge_wr_data,
  output bus_data_t            bridge_rd_data,
  // program fetch port
  input  wire                  pgm_req,
  input  wire rom_word_addr_t  pgm_addr,
  output rom_word_t            pgm_data,
  output logic                 pgm_valid,
  // raw pixel stream
  input  wire                  ce_pix,
  input  wire                  hsync,
  input  wire                  vsync,
  input  wire                  hblank,
  input  wire                  vblank,
  input  wire                  pixel,
  // buzzer levels
  input  wire                  buzzer1,
  input  wire                  buzzer2,
  // scaler video
  output rgb_t                 video_rgb,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs,
  // i2s
  output logic                 audio_mclk,
  output logic                 audio_lrck,
  output logic                 audio_dac
);

  // loader to arbiter
  logic            ld_wr_req;
  rom_byte_addr_t  ld_wr_addr;
  logic [7:0]      ld_wr_byte;
  bus_data_t       byte_count;

  // arbiter to rom
  rom_word_addr_t  rom_addr;
  logic            rom_we;
  logic            rom_byte_hi;
  logic [7:0]      rom_wdata;
  rom_word_t       rom_q;

  // result registers for the bridge
  rom_word_t       read_data;
  rom_word_addr_t  last_pgm_addr;

  ////////////////////////////////////////////////////////////////////////////
  // bridge readback mux

  always_comb
  begin
    case (bridge_addr)
      REG_READ_DATA:  bridge_rd_data = {16'h0000, read_data};
      REG_BYTE_COUNT: bridge_rd_data = byte_count;
      REG_PGM_ADDR:   bridge_rd_data = {18'h00000, last_pgm_addr};
      REG_PGM_DATA:   bridge_rd_data = {16'h0000, pgm_data};
      default:        bridge_rd_data = '0;
    endcase
  end

  // host never issues a read and a write in one cycle
  a_bridge_rd_wr_excl: assert property (@(posedge clk_74a) disable iff (!rst_n)
    !(bridge_rd && bridge_wr));

  ////////////////////////////////////////////////////////////////////////////
  // rom and its three peers

  rom_loader u_rom_loader (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .wr_req         (ld_wr_req),
    .wr_addr        (ld_wr_addr),
    .wr_byte        (ld_wr_byte),
    .byte_count     (byte_count)
  );

  rom_arbiter u_rom_arbiter (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .wr_req         (ld_wr_req),
    .wr_addr        (ld_wr_addr),
    .wr_byte        (ld_wr_byte),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .pgm_req        (pgm_req),
    .pgm_addr       (pgm_addr),
    .rom_q          (rom_q),
    .rom_addr       (rom_addr),
    .rom_we         (rom_we),
    .rom_byte_hi    (rom_byte_hi),
    .rom_wdata      (rom_wdata),
    .read_data      (read_data),
    .pgm_data       (pgm_data),
    .pgm_valid      (pgm_valid),
    .last_pgm_addr  (last_pgm_addr)
  );

  program_rom u_program_rom (
    .clk_74a (clk_74a),
    .addr    (rom_addr),
    .we      (rom_we),
    .byte_hi (rom_byte_hi),
    .wdata   (rom_wdata),
    .q       (rom_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // video and audio

  video_cleanup u_video_cleanup (
    .clk_74a   (clk_74a),
    .rst_n     (rst_n),
    .ce_pix    (ce_pix),
    .hsync     (hsync),
    .vsync     (vsync),
    .hblank    (hblank),
    .vblank    (vblank),
    .pixel     (pixel),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

  i2s_audio u_i2s_audio (
    .clk_74a    (clk_74a),
    .rst_n      (rst_n),
    .buzzer1    (buzzer1),
    .buzzer2    (buzzer2),
    .audio_mclk (audio_mclk),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

endmodule

`default_nettype wire

//--- logic/i2s_audio.sv
// i2s square wave output
// fractional mclk from clk_74a, bit clock at mclk/4, and a 16 bit
// sample in each 32 bit slot. both channels carry the buzzer mix

`timescale 1ns/1ps
`default_nettype none

module i2s_audio
  import av_pkg::*;
(
  input  wire   clk_74a,
  input  wire   rst_n,
  input  wire   buzzer1,
  input  wire   buzzer2,
  output logic  audio_mclk,
  output logic  audio_lrck,
  output logic  audio_dac
);

  localparam int DIV_W = $clog2(SCLK_DIV);
  localparam int CNT_W = $clog2(SLOT_BITS);

  accum_t                accum;
  logic                  mclk_toggle;
  logic                  mclk_rise;
  logic [DIV_W-1:0]      mclk_div;
  logic                  sclk_fall;
  logic [CNT_W-1:0]      bit_cnt;
  logic [SLOT_BITS-1:0]  shift_reg;
  sample_t               sample;

  ////////////////////////////////////////////////////////////////////////////
  // mclk, ~12.288 MHz

  assign mclk_toggle = (accum >= MCLK_WRAP);

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      accum      <= '0;
      audio_mclk <= 1'b0;
    end
    else if (mclk_toggle)
    begin
      accum      <= accum - MCLK_WRAP + MCLK_STEP;
      audio_mclk <= !audio_mclk;
    end
    else
      accum <= accum + MCLK_STEP;
  end

  ////////////////////////////////////////////////////////////////////////////
  // bit clock enable

  // mclk about to rise
  assign mclk_rise = mclk_toggle && !audio_mclk;
  // sclk falls when the divider wraps
  assign sclk_fall = mclk_rise && (mclk_div == DIV_W'(SCLK_DIV - 1));

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
      mclk_div <= '0;
    else if (mclk_rise)
      mclk_div <= mclk_div + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // sample mix and shifter

  // unsigned-looking levels, top bits stay clear
  always_comb
  begin
    sample = (buzzer1 ? TONE_LEVEL : sample_t'(0)) + (buzzer2 ? TONE_LEVEL : sample_t'(0));
  end

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt    <= '0;
      shift_reg  <= '0;
      audio_lrck <= 1'b0;
      audio_dac  <= 1'b0;
    end
    else if (sclk_fall)
    begin
      bit_cnt   <= bit_cnt + 1'b1;
      // msb follows the lrck edge by one bit
      audio_dac <= shift_reg[SLOT_BITS-1];
      if (bit_cnt == CNT_W'(SLOT_BITS - 1))
      begin
        // next channel, same sample, zero padded
        audio_lrck <= !audio_lrck;
        shift_reg  <= {sample, {(SLOT_BITS - ACTIVE_BITS){1'b0}}};
      end
      else
        shift_reg <= {shift_reg[SLOT_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

//--- logic/program_rom.sv
// program rom
// 16 bit words with byte lane writes and one registered read port

`timescale 1ns/1ps
`default_nettype none

module program_rom
  import rom_pkg::*;
(
  input  wire                  clk_74a,
  input  wire rom_word_addr_t  addr,
  input  wire                  we,
  input  wire                  byte_hi,
  input  wire [7:0]            wdata,
  output rom_word_t            q
);

  // lane 0 is the even byte
  logic [1:0][7:0] mem [ROM_WORDS];

  always_ff @(posedge clk_74a)
  begin
    if (we)
      mem[addr][byte_hi] <= wdata;
    // old word on a write cycle, nobody reads then anyway
    q <= mem[addr];
  end

endmodule

`default_nettype wire

//--- logic/rom_arbiter.sv
// rom arbiter
// single rom port shared by loader writes, bridge readback and program
// fetch, fixed priority in that order. holds the result registers

`timescale 1ns/1ps
`default_nettype none

module rom_arbiter
  import rom_pkg::*;
(
  input  wire                  clk_74a,
  input  wire                  rst_n,
  // loader
  input  wire                  wr_req,
  input  wire rom_byte_addr_t  wr_addr,
  input  wire [7:0]            wr_byte,
  // bridge
  input  wire bus_addr_t       bridge_addr,
  input  wire                  bridge_wr,
  input  wire bus_data_t       bridge_wr_data,
  // fetch
  input  wire                  pgm_req,
  input  wire rom_word_addr_t  pgm_addr,
  // rom port
  input  wire rom_word_t       rom_q,
  output rom_word_addr_t       rom_addr,
  output logic                 rom_we,
  output logic                 rom_byte_hi,
  output logic [7:0]           rom_wdata,
  // results
  output rom_word_t            read_data,
  output rom_word_t            pgm_data,
  output logic                 pgm_valid,
  output rom_word_addr_t       last_pgm_addr
);

  logic            rb_new;
  logic            rb_pending;
  logic            rb_req;
  rom_word_addr_t  rb_addr;
  rom_word_addr_t  rb_addr_now;
  logic            grant_wr;
  logic            grant_rb;
  logic            grant_pf;
  // owner of the read in flight
  logic            own_rb;
  logic            own_pf;

  ////////////////////////////////////////////////////////////////////////////
  // requests and grants

  assign rb_new      = bridge_wr && (bridge_addr == REG_READ_ADDR);
  assign rb_req      = rb_pending || rb_new;
  // fresh address bypasses the latch so an idle port reads right away
  assign rb_addr_now = rb_new ? bridge_wr_data[13:0] : rb_addr;

  // loader never waits
  assign grant_wr = wr_req;
  assign grant_rb = rb_req && !wr_req;
  // hold off a repeat while the previous fetch is still returning
  assign grant_pf = pgm_req && !wr_req && !rb_req && !own_pf && !pgm_valid;

  always_comb
  begin
    if (grant_wr)
      rom_addr = wr_addr[14:1];
    else if (grant_rb)
      rom_addr = rb_addr_now;
    else
      rom_addr = pgm_addr;
  end

  assign rom_we      = grant_wr;
  assign rom_byte_hi = wr_addr[0];
  assign rom_wdata   = wr_byte;

  ////////////////////////////////////////////////////////////////////////////
  // pending state and read ownership

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rb_pending <= 1'b0;
      own_rb     <= 1'b0;
      own_pf     <= 1'b0;
      pgm_valid  <= 1'b0;
    end
    else
    begin
      rb_pending <= rb_req && !grant_rb;
      own_rb     <= grant_rb;
      own_pf     <= grant_pf;
      // rom q lands one cycle after grant, registered here one more
      pgm_valid  <= own_pf;
    end
  end

  // steer returning word
  always_ff @(posedge clk_74a)
  begin
    if (rb_new)
      rb_addr <= bridge_wr_data[13:0];
    if (own_rb)
      read_data <= rom_q;
    if (own_pf)
      pgm_data <= rom_q;
    if (grant_pf)
      last_pgm_addr <= pgm_addr;
  end

  a_grant_onehot: assert property (@(posedge clk_74a) disable iff (!rst_n)
    $onehot0({grant_wr, grant_rb, grant_pf}));

  // valid two cycles after its own grant, never from a readback
  a_valid_after_fetch: assert property (@(posedge clk_74a) disable iff (!rst_n)
    pgm_valid |-> $past(grant_pf, 2));

endmodule

`default_nettype wire

//--- logic/rom_loader.sv
// rom loader
// turns each 32 bit bridge write in the load region into four byte
// writes, MSB first, and keeps a running byte count

`timescale 1ns/1ps
`default_nettype none

module rom_loader
  import rom_pkg::*;
(
  input  wire             clk_74a,
  input  wire             rst_n,
  input  wire bus_addr_t  bridge_addr,
  input  wire             bridge_wr,
  input  wire bus_data_t  bridge_wr_data,
  output logic            wr_req,
  output rom_byte_addr_t  wr_addr,
  output logic [7:0]      wr_byte,
  output bus_data_t       byte_count
);

  logic            load_hit;
  logic            busy;
  logic [1:0]      byte_idx;
  bus_data_t       shift_word;
  rom_byte_addr_t  base_addr;

  // only the upper nibble decodes the region
  assign load_hit = bridge_wr && (bridge_addr[31:28] == LOAD_REGION);

  // byte sequencer, four cycles per word
  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      byte_idx <= 2'd0;
    end
    else if (busy)
    begin
      // index wraps back to zero on the last byte
      byte_idx <= byte_idx + 2'd1;
      if (byte_idx == 2'd3)
        busy <= 1'b0;
    end
    else if (load_hit)
    begin
      busy     <= 1'b1;
      byte_idx <= 2'd0;
    end
  end

  // word and base address, big-endian so top byte leaves first
  always_ff @(posedge clk_74a)
  begin
    if (busy)
      shift_word <= {shift_word[23:0], 8'h00};
    else if (load_hit)
    begin
      shift_word <= bridge_wr_data;
      base_addr  <= bridge_addr[14:0];
    end
  end

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
      byte_count <= '0;
    else if (busy)
      byte_count <= byte_count + 32'd1;
  end

  assign wr_req  = busy;
  assign wr_addr = base_addr + {13'b0, byte_idx};
  assign wr_byte = shift_word[31:24];

  // host spacing keeps words from overlapping
  a_no_overlap: assert property (@(posedge clk_74a) disable iff (!rst_n)
    load_hit |-> !busy);

endmodule

`default_nettype wire

//--- logic/rom_pkg.sv
// rom package
// bridge address map, program ROM geometry and the word types that
// travel between the loader, the arbiter and the ROM

`default_nettype none

package rom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus words

  // bridge bus is 32 bit, big-endian on the data side
  typedef logic [31:0] bus_data_t;
  typedef logic [31:0] bus_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // rom geometry

  // 32 KiB of program space, 16k words
  localparam int ROM_WORDS = 16384;

  typedef logic [14:0] rom_byte_addr_t;
  typedef logic [13:0] rom_word_addr_t;
  // even byte address sits in the low byte
  typedef logic [15:0] rom_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // bridge address map

  // upper nibble of a rom load write
  localparam logic [3:0] LOAD_REGION = 4'h0;

  // readback registers, same space as the load region on the read side
  localparam bus_addr_t REG_READ_DATA  = 32'h0000_0000;
  localparam bus_addr_t REG_BYTE_COUNT = 32'h0000_0004;
  localparam bus_addr_t REG_PGM_ADDR   = 32'h0000_000C;
  localparam bus_addr_t REG_PGM_DATA   = 32'h0000_0010;
  // write-only, word address to read back
  localparam bus_addr_t REG_READ_ADDR  = 32'h1000_0000;

endpackage

`default_nettype wire

//--- logic/video_cleanup.sv
// video cleanup for the scaler
// single cycle hs/vs on sync rising edges, de from the blanks and
// RGB forced black outside de

`timescale 1ns/1ps
`default_nettype none

module video_cleanup
  import av_pkg::*;
(
  input  wire    clk_74a,
  input  wire    rst_n,
  input  wire    ce_pix,
  input  wire    hsync,
  input  wire    vsync,
  input  wire    hblank,
  input  wire    vblank,
  input  wire    pixel,
  output rgb_t   video_rgb,
  output logic   video_de,
  output logic   video_hs,
  output logic   video_vs
);

  logic hs_prev;
  logic vs_prev;
  logic de_now;

  assign de_now = !(hblank || vblank);

  always_ff @(posedge clk_74a or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= RGB_OFF;
    end
    else if (ce_pix)
    begin
      // edge detect at pixel rate
      video_hs  <= hsync && !hs_prev;
      video_vs  <= vsync && !vs_prev;
      hs_prev   <= hsync;
      vs_prev   <= vsync;
      video_de  <= de_now;
      video_rgb <= (de_now && pixel) ? RGB_ON : RGB_OFF;
    end
    else
    begin
      // scaler wants one clk wide syncs
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end
  end

  a_hs_single: assert property (@(posedge clk_74a) disable iff (!rst_n)
    video_hs |=> !video_hs);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_core_top -Mdir obj_dir -o sim_core_top &&
out=$(./obj_dir/sim_core_top) &&
echo "$out" &&
echo "$out" | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- test/tb_core_top.sv
// testbench for the handheld core top level
// directed tests for ROM load, readback, program fetch under contention,
// video cleanup and I2S audio, checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_core_top
  import rom_pkg::*;
  import av_pkg::*;
;

  // two audio frames plus margin
  localparam int TIMEOUT_CYCLES = 20000;

  // {hsync, vsync, hblank, vblank, pixel} per pixel step, step 0 first
  localparam logic [16*5-1:0] VIDEO_SCRIPT = {
    5'b00100, 5'b10100, 5'b10101, 5'b00100, 5'b00001, 5'b00000, 5'b00001, 5'b00011,
    5'b01010, 5'b11110, 5'b01111, 5'b00010, 5'b00001, 5'b10001, 5'b00001, 5'b00000
  };

  logic            clk_74a;
  logic            rst_n;
  bus_addr_t       bridge_addr;
  logic            bridge_wr;
  logic            bridge_rd;
  bus_data_t       bridge_wr_data;
  bus_data_t       bridge_rd_data;
  logic            pgm_req;
  rom_word_addr_t  pgm_addr;
  rom_word_t       pgm_data;
  logic            pgm_valid;
  logic            ce_pix;
  logic            hsync;
  logic            vsync;
  logic            hblank;
  logic            vblank;
  logic            pixel;
  logic            buzzer1;
  logic            buzzer2;
  rgb_t            video_rgb;
  logic            video_de;
  logic            video_hs;
  logic            video_vs;
  logic            audio_mclk;
  logic            audio_lrck;
  logic            audio_dac;

  integer          seed;
  int              error_count;
  int              check_count;
  int              cycle_count;
  // reference copy of the ROM contents
  rom_word_t       model_rom [ROM_WORDS];
  rom_byte_addr_t  loaded_bytes [$];

  core_top u_dut (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_rd      (bridge_rd),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .pgm_req        (pgm_req),
    .pgm_addr       (pgm_addr),
    .pgm_data       (pgm_data),
    .pgm_valid      (pgm_valid),
    .ce_pix         (ce_pix),
    .hsync          (hsync),
    .vsync          (vsync),
    .hblank         (hblank),
    .vblank         (vblank),
    .pixel          (pixel),
    .buzzer1        (buzzer1),
    .buzzer2        (buzzer2),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs),
    .audio_mclk     (audio_mclk),
    .audio_lrck     (audio_lrck),
    .audio_dac      (audio_dac)
  );

  initial
  begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  // cycle counter, ends a hung run
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk_74a);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_word(input rom_word_t got, input rom_word_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bus(input bus_data_t got, input bus_data_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0d ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus helpers

  // every task starts and ends 1 ns after a rising edge
  task automatic step_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  // big-endian word, byte addr+0 gets bits 31:24, even byte is the low lane
  task automatic model_store(input rom_byte_addr_t addr, input bus_data_t data);
    rom_byte_addr_t a;
    logic [7:0]     b;
    for (int i = 0; i < 4; i++)
    begin
      a = addr + 15'(i);
      b = data[31 - 8*i -: 8];
      if (a[0])
        model_rom[a[14:1]][15:8] = b;
      else
        model_rom[a[14:1]][7:0] = b;
    end
  endtask

  task automatic rom_write(input rom_byte_addr_t addr, input bus_data_t data);
    model_store(addr, data);
    bridge_addr    = {17'b0, addr};
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step_cycle();
    bridge_wr = 1'b0;
    // loader spends four cycles on the bytes
    repeat (4) step_cycle();
  endtask

  task automatic reg_write(input bus_addr_t addr, input bus_data_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    step_cycle();
    bridge_wr = 1'b0;
  endtask

  // read mux is combinational, sample mid cycle
  task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    #5;
    data = bridge_rd_data;
    step_cycle();
    bridge_rd = 1'b0;
  endtask

  task automatic read_back(input rom_word_addr_t waddr, output bus_data_t data);
    reg_write(REG_READ_ADDR, {18'b0, waddr});
    repeat (2) step_cycle();
    bus_read(REG_READ_DATA, data);
  endtask

  // hold the request level until the valid pulse
  task automatic fetch_word(input rom_word_addr_t addr, output rom_word_t data);
    pgm_addr = addr;
    pgm_req  = 1'b1;
    step_cycle();
    while (!pgm_valid)
      step_cycle();
    data    = pgm_data;
    pgm_req = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic load_and_count();
    bus_data_t       r;
    bus_data_t       rd;
    rom_byte_addr_t  a;
    for (int i = 0; i < 8; i++)
    begin
      r = $random(seed);
      a = {r[14:2], 2'b00};
      loaded_bytes.push_back(a);
      rom_write(a, $random(seed));
    end
    bus_read(REG_BYTE_COUNT, rd);
    check_bus(rd, 32'd32, "byte count after 8 words");
    foreach (loaded_bytes[i])
    begin
      for (int w = 0; w < 2; w++)
      begin
        a = loaded_bytes[i] + 15'(2*w);
        read_back(a[14:1], rd);
        check_bus(rd, {16'h0000, model_rom[a[14:1]]}, "readback word");
      end
    end
  endtask

  task automatic program_fetch();
    rom_word_addr_t  wa;
    rom_word_t       got;
    bus_data_t       rd;
    for (int i = 0; i < 6; i++)
    begin
      wa = loaded_bytes[i/2][14:1] + 14'(i % 2);
      fetch_word(wa, got);
      check_word(got, model_rom[wa], "fetched word");
      bus_read(REG_PGM_ADDR, rd);
      check_bus(rd, {18'b0, wa}, "last fetch address");
      bus_read(REG_PGM_DATA, rd);
      check_bus(rd, {16'h0000, model_rom[wa]}, "last fetch data");
    end
  endtask

  task automatic fetch_contention();
    rom_byte_addr_t  a;
    rom_word_addr_t  wa;
    rom_word_t       got;
    bus_data_t       rd;
    for (int i = 0; i < 3; i++)
    begin
      a  = loaded_bytes[i];
      // second word of the burst takes the last two bytes
      wa = a[14:1] + 14'd1;
      fork
        rom_write(a, $random(seed));
        begin
          step_cycle();
          fetch_word(wa, got);
        end
      join
      check_word(got, model_rom[wa], "fetch stalled by loader");
    end
    bus_read(REG_BYTE_COUNT, rd);
    check_bus(rd, 32'd44, "byte count after contention");
  endtask

  task automatic video_pattern();
    logic [4:0]  st;
    logic        h_prev;
    logic        v_prev;
    logic        de_exp;
    rgb_t        rgb_exp;
    h_prev = 1'b0;
    v_prev = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      st = VIDEO_SCRIPT[(15 - i)*5 +: 5];
      {hsync, vsync, hblank, vblank, pixel} = st;
      ce_pix = 1'b1;
      step_cycle();
      ce_pix  = 1'b0;
      de_exp  = !(st[2] || st[1]);
      rgb_exp = (de_exp && st[0]) ? RGB_ON : RGB_OFF;
      check_bit(video_hs, st[4] && !h_prev, "hs on pixel step");
      check_bit(video_vs, st[3] && !v_prev, "vs on pixel step");
      check_bit(video_de, de_exp, "de on pixel step");
      check_rgb(video_rgb, rgb_exp, "rgb on pixel step");
      h_prev = st[4];
      v_prev = st[3];
      step_cycle();
      // syncs one clock wide, the rest held
      check_bit(video_hs, 1'b0, "hs cleared");
      check_bit(video_vs, 1'b0, "vs cleared");
      check_bit(video_de, de_exp, "de held");
      check_rgb(video_rgb, rgb_exp, "rgb held");
      step_cycle();
    end
    {hsync, vsync, hblank, vblank, pixel} = 5'b00000;
  endtask

  task automatic wait_mclk_rise();
    logic prev;
    logic found;
    prev  = audio_mclk;
    found = 1'b0;
    while (!found)
    begin
      step_cycle();
      found = !prev && audio_mclk;
      prev  = audio_mclk;
    end
  endtask

  task automatic wait_lrck_edge();
    logic prev;
    prev = audio_lrck;
    while (audio_lrck == prev)
      wait_mclk_rise();
  endtask

  // one slot of 32 bits at 4 mclk each, starting on an lrck edge
  task automatic check_slot(input rom_word_t exp);
    logic       lr;
    rom_word_t  got;
    int         k;
    lr  = audio_lrck;
    got = '0;
    for (int r = 1; r <= 128; r++)
    begin
      wait_mclk_rise();
      if (r < 128)
        check_bit(audio_lrck, lr, "lrck held inside slot");
      else
        check_bit(audio_lrck, !lr, "lrck toggles after 128 mclk");
      if (r % 4 == 2)
      begin
        k = r / 4;
        if (k >= 1 && k <= ACTIVE_BITS)
          got = {got[14:0], audio_dac};
        else
          check_bit(audio_dac, 1'b0, "slot padding bit");
      end
    end
    check_word(got, exp, "slot sample bits");
  endtask

  task automatic mclk_ratio();
    int     start;
    longint span;
    longint ideal;
    longint tol;
    logic   prev;
    prev = audio_mclk;
    while (audio_mclk == prev)
      step_cycle();
    start = cycle_count;
    for (int t = 0; t < 1000; t++)
    begin
      prev = audio_mclk;
      while (audio_mclk == prev)
        step_cycle();
    end
    // one clk_74a cycle in accumulator units
    tol   = longint'(MCLK_STEP);
    span  = longint'(cycle_count - start) * tol;
    ideal = longint'(1000) * longint'(MCLK_WRAP);
    check_bit((span - ideal <= tol) && (ideal - span <= tol), 1'b1,
      $sformatf("%0d cycles for 1000 mclk toggles", cycle_count - start));
  endtask

  task automatic audio_tone();
    buzzer1 = 1'b1;
    buzzer2 = 1'b0;
    wait_lrck_edge();
    // left then right, same sample
    check_slot(16'h2000);
    check_slot(16'h2000);
    mclk_ratio();
    buzzer2 = 1'b1;
    wait_lrck_edge();
    check_slot(16'h4000);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    seed           = 32'h1ebc229a;
    error_count    = 0;
    check_count    = 0;
    rst_n          = 1'b0;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_rd      = 1'b0;
    bridge_wr_data = '0;
    pgm_req        = 1'b0;
    pgm_addr       = '0;
    ce_pix         = 1'b0;
    hsync          = 1'b0;
    vsync          = 1'b0;
    hblank         = 1'b0;
    vblank         = 1'b0;
    pixel          = 1'b0;
    buzzer1        = 1'b0;
    buzzer2        = 1'b0;
    repeat (3) @(posedge clk_74a);
    #1;
    rst_n = 1'b1;
    step_cycle();

    load_and_count();
    program_fetch();
    fetch_contention();
    video_pattern();
    audio_tone();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
logic/rom_pkg.sv
logic/av_pkg.sv
logic/program_rom.sv
logic/rom_loader.sv
logic/rom_arbiter.sv
logic/video_cleanup.sv
logic/i2s_audio.sv
logic/core_top.sv
test/tb_core_top.sv
